// File: hdl/fft_twiddle_16.svh
`ifndef FFT_TWIDDLE_16_SVH
`define FFT_TWIDDLE_16_SVH

// twiddle applied between the two stages, indexed by sample slot k
// entry k holds W16^((k mod 4) * bitrev2(k / 4))
// slots 0..3 and every slot with k mod 4 == 0 multiply by 1
localparam logic signed [TF_WIDTH-1:0] TW16_RE [FFT_LEN] = '{
  10'sd256, 10'sd256, 10'sd256, 10'sd256,
  10'sd256, 10'sd181, 10'sd0, -10'sd181,
  10'sd256, 10'sd237, 10'sd181, 10'sd98,
  10'sd256, 10'sd98, -10'sd181, -10'sd237
};

localparam logic signed [TF_WIDTH-1:0] TW16_IM [FFT_LEN] = '{
  10'sd0, 10'sd0, 10'sd0, 10'sd0,
  10'sd0, -10'sd181, -10'sd256, -10'sd181,
  10'sd0, -10'sd98, -10'sd181, -10'sd237,
  10'sd0, -10'sd237, -10'sd181, 10'sd98
};

`endif

// File: hdl/fft_pkg.sv
`default_nettype none

package fft_pkg;

  // transform size
  localparam int FFT_LOG2 = 4;
  localparam int FFT_LEN = 1 << FFT_LOG2;

  // twiddle words are signed Q1.8 per component
  localparam int TF_WIDTH = 10;
  // 1.0 is 256, so 1, -1 and +-j are exact
  localparam int TF_FRAC = 8;

  // default input component width
  localparam int DIN_WIDTH_DEF = 12;

  // growth per radix-2^2 stage, one bit for each butterfly
  // the twiddle multiply keeps its input width
  localparam int STAGE_GROWTH = 2;

  // sample slot within a frame
  typedef logic [FFT_LOG2-1:0] idx_t;

  // output enable FSM
  typedef enum logic {
    FILL,
    STREAM
  } out_state_t;

endpackage

`default_nettype wire

// File: hdl/fft_delay_line.sv
`timescale 1ns/1ns
`default_nettype none

module fft_delay_line #(
  parameter int DEPTH = 8,
  parameter type item_t = logic
) (
  input  wire   clk,
  input  wire   rst_n,
  input  wire   shift,
  input  wire   item_t din,
  output item_t dout
);

  item_t mem [DEPTH];

  // moves only on accepted samples, holds through idle cycles
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < DEPTH; i++)
      begin
        mem[i] <= '0;
      end
    end
    else if (shift)
    begin
      mem[0] <= din;
      for (int i = 1; i < DEPTH; i++)
      begin
        mem[i] <= mem[i-1];
      end
    end
  end

  // item written DEPTH shifts ago
  assign dout = mem[DEPTH-1];

endmodule

`default_nettype wire

// File: hdl/fft_sample_counter.sv
`timescale 1ns/1ns
`default_nettype none

module fft_sample_counter (
  input  wire           clk,
  input  wire           rst_n,
  input  wire           step,
  output fft_pkg::idx_t count,
  output logic          wrap
);

  import fft_pkg::*;

  // free running modulo FFT_LEN, advances on step only
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      count <= '0;
    end
    else if (step)
    begin
      count <= count + idx_t'(1);
    end
  end

  // last slot of the frame, a step here closes it
  assign wrap = (count == idx_t'(FFT_LEN - 1));

  a_hold_idle: assert property (@(posedge clk) disable iff (!rst_n) !step |=> $stable(count));

endmodule

`default_nettype wire

// File: hdl/fft_bf2_section.sv
`timescale 1ns/1ns
`default_nettype none

module fft_bf2_section #(
  parameter int X_WIDTH = 12,
  parameter int DELAY = 8,
  parameter bit ROTATE = 1'b0
) (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire signed [X_WIDTH-1:0] x_re,
  input  wire signed [X_WIDTH-1:0] x_im,
  input  wire fft_pkg::idx_t       x_tag,
  input  wire                      x_nd,
  output logic signed [X_WIDTH:0]  z_re,
  output logic signed [X_WIDTH:0]  z_im,
  output fft_pkg::idx_t            z_tag,
  output logic                     z_nd
);

  import fft_pkg::*;

  // tag bit that splits each block of 2*DELAY samples
  localparam int SEL_BIT = $clog2(DELAY);

  typedef struct packed {
    logic signed [X_WIDTH:0] re;
    logic signed [X_WIDTH:0] im;
  } cplx_t;

  cplx_t                   fb_in;
  cplx_t                   fb_out;
  idx_t                    tag_dly;
  logic                    second_half;
  logic                    rot;
  logic signed [X_WIDTH:0] a_re;
  logic signed [X_WIDTH:0] a_im;
  logic signed [X_WIDTH:0] sum_re;
  logic signed [X_WIDTH:0] sum_im;
  logic signed [X_WIDTH:0] dif_re;
  logic signed [X_WIDTH:0] dif_im;

  assign second_half = x_tag[SEL_BIT];

  // -j on the lower input in the last quarter of each 4*DELAY block
  if (ROTATE)
  begin : g_rot
    assign rot = x_tag[SEL_BIT] & x_tag[SEL_BIT+1];
  end
  else
  begin : g_no_rot
    assign rot = 1'b0;
  end

  always_comb
  begin
    if (rot)
    begin
      a_re = (X_WIDTH+1)'(x_im);
      a_im = -(X_WIDTH+1)'(x_re);
    end
    else
    begin
      a_re = (X_WIDTH+1)'(x_re);
      a_im = (X_WIDTH+1)'(x_im);
    end
  end

  // upper sample comes back out of the feedback line
  assign sum_re = fb_out.re + a_re;
  assign sum_im = fb_out.im + a_im;
  assign dif_re = fb_out.re - a_re;
  assign dif_im = fb_out.im - a_im;

  // first half parks the input, second half parks the difference
  assign fb_in.re = second_half ? dif_re : a_re;
  assign fb_in.im = second_half ? dif_im : a_im;

  fft_delay_line #(
    .DEPTH  (DELAY),
    .item_t (cplx_t)
  ) u_fb_dly (
    .clk   (clk),
    .rst_n (rst_n),
    .shift (x_nd),
    .din   (fb_in),
    .dout  (fb_out)
  );

  // slot of the sample that leaves, DELAY accepted samples back
  fft_delay_line #(
    .DEPTH  (DELAY),
    .item_t (idx_t)
  ) u_tag_dly (
    .clk   (clk),
    .rst_n (rst_n),
    .shift (x_nd),
    .din   (x_tag),
    .dout  (tag_dly)
  );

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      z_nd  <= 1'b0;
      z_tag <= '0;
    end
    else
    begin
      z_nd <= x_nd;
      if (x_nd)
        z_tag <= tag_dly;
    end
  end

  always_ff @(posedge clk)
  begin
    if (x_nd)
    begin
      z_re <= second_half ? sum_re : fb_out.re;
      z_im <= second_half ? sum_im : fb_out.im;
    end
  end

  a_nd_follows: assert property (@(posedge clk) disable iff (!rst_n) x_nd |=> z_nd);
  a_nd_quiet: assert property (@(posedge clk) disable iff (!rst_n) !x_nd |=> !z_nd);

endmodule

`default_nettype wire

// File: hdl/fft_twiddle_mult.sv
`timescale 1ns/1ns
`default_nettype none

module fft_twiddle_mult #(
  parameter int X_WIDTH = 14
) (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire signed [X_WIDTH-1:0]  x_re,
  input  wire signed [X_WIDTH-1:0]  x_im,
  input  wire fft_pkg::idx_t        x_tag,
  input  wire                       x_nd,
  output logic signed [X_WIDTH-1:0] z_re,
  output logic signed [X_WIDTH-1:0] z_im,
  output fft_pkg::idx_t             z_tag,
  output logic                      z_nd
);

  import fft_pkg::*;

  `include "fft_twiddle_16.svh"

  // full product plus one bit for the cross term sum
  localparam int P_WIDTH = X_WIDTH + TF_WIDTH + 1;

  // half an output lsb, for round half up
  localparam logic signed [P_WIDTH-1:0] HALF_LSB =
    {{(P_WIDTH-TF_FRAC){1'b0}}, 1'b1, {(TF_FRAC-1){1'b0}}};

  logic signed [TF_WIDTH-1:0] tw_re;
  logic signed [TF_WIDTH-1:0] tw_im;
  logic signed [P_WIDTH-1:0]  p_re;
  logic signed [P_WIDTH-1:0]  p_im;

  assign tw_re = TW16_RE[x_tag];
  assign tw_im = TW16_IM[x_tag];

  // (a + jb)(c + jd) = (ac - bd) + j(ad + bc)
  always_comb
  begin
    p_re = P_WIDTH'(x_re) * P_WIDTH'(tw_re) - P_WIDTH'(x_im) * P_WIDTH'(tw_im) + HALF_LSB;
    p_im = P_WIDTH'(x_re) * P_WIDTH'(tw_im) + P_WIDTH'(x_im) * P_WIDTH'(tw_re) + HALF_LSB;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      z_nd  <= 1'b0;
      z_tag <= '0;
    end
    else
    begin
      z_nd <= x_nd;
      if (x_nd)
        z_tag <= x_tag;
    end
  end

  // drop the fraction bits, sample slot is unchanged here
  always_ff @(posedge clk)
  begin
    if (x_nd)
    begin
      z_re <= p_re[TF_FRAC +: X_WIDTH];
      z_im <= p_im[TF_FRAC +: X_WIDTH];
    end
  end

endmodule

`default_nettype wire

// File: hdl/fft_output_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module fft_output_ctrl #(
  parameter int X_WIDTH = 16
) (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire signed [X_WIDTH-1:0]  x_re,
  input  wire signed [X_WIDTH-1:0]  x_im,
  input  wire fft_pkg::idx_t        x_tag,
  input  wire                       x_nd,
  output logic signed [X_WIDTH-1:0] dout_re,
  output logic signed [X_WIDTH-1:0] dout_im,
  output logic                      dout_nd,
  output fft_pkg::idx_t             out_num
);

  import fft_pkg::*;

  out_state_t state;
  idx_t       res_count;
  logic       res_wrap;
  logic       first_slot;
  logic       release_nd;

  // counts every arrival, so in STREAM it tracks the slot of the result
  fft_sample_counter u_res_cnt (
    .clk   (clk),
    .rst_n (rst_n),
    .step  (x_nd),
    .count (res_count),
    .wrap  (res_wrap)
  );

  // pipeline is N-1 samples deep, 16th arrival is slot 0 of frame 0
  assign first_slot = (state == FILL) && x_nd && res_wrap && (x_tag == '0);
  assign release_nd = x_nd && ((state == STREAM) || first_slot);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= FILL;
      dout_nd <= 1'b0;
    end
    else
    begin
      dout_nd <= release_nd;
      if (first_slot)
        state <= STREAM;
    end
  end

  always_ff @(posedge clk)
  begin
    if (release_nd)
    begin
      dout_re <= x_re;
      dout_im <= x_im;
    end
  end

  // bit-reversed slot is the natural bin index
  always_comb
  begin
    out_num = '0;
    if (state == STREAM)
    begin
      for (int i = 0; i < FFT_LOG2; i++)
      begin
        out_num[i] = res_count[FFT_LOG2-1-i];
      end
    end
  end

  a_stay_stream: assert property (@(posedge clk) disable iff (!rst_n)
    state == STREAM |=> state == STREAM);

  // slot tags through the whole chain stay in step with the result count
  a_tag_in_order: assert property (@(posedge clk) disable iff (!rst_n)
    (state == STREAM && x_nd) |-> x_tag == idx_t'(res_count + idx_t'(1)));

endmodule

`default_nettype wire

// File: hdl/fft_r22sdf_16.sv
`timescale 1ns/1ns
`default_nettype none

module fft_r22sdf_16 #(
  parameter int DIN_WIDTH = fft_pkg::DIN_WIDTH_DEF,
  localparam int DOUT_WIDTH = DIN_WIDTH + 2 * fft_pkg::STAGE_GROWTH
) (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire signed [DIN_WIDTH-1:0]   din_re,
  input  wire signed [DIN_WIDTH-1:0]   din_im,
  input  wire                          din_nd,
  output logic signed [DOUT_WIDTH-1:0] dout_re,
  output logic signed [DOUT_WIDTH-1:0] dout_im,
  output logic                         dout_nd,
  output fft_pkg::idx_t                out_num
);

  import fft_pkg::*;

  // widths along the chain, the multiplier keeps its width
  localparam int S0A_WIDTH = DIN_WIDTH + 1;
  localparam int S0_WIDTH  = DIN_WIDTH + STAGE_GROWTH;
  localparam int S1A_WIDTH = S0_WIDTH + 1;

  idx_t                        in_tag;
  logic signed [S0A_WIDTH-1:0] s0a_re;
  logic signed [S0A_WIDTH-1:0] s0a_im;
  idx_t                        s0a_tag;
  logic                        s0a_nd;
  logic signed [S0_WIDTH-1:0]  s0b_re;
  logic signed [S0_WIDTH-1:0]  s0b_im;
  idx_t                        s0b_tag;
  logic                        s0b_nd;
  logic signed [S0_WIDTH-1:0]  tm_re;
  logic signed [S0_WIDTH-1:0]  tm_im;
  idx_t                        tm_tag;
  logic                        tm_nd;
  logic signed [S1A_WIDTH-1:0] s1a_re;
  logic signed [S1A_WIDTH-1:0] s1a_im;
  idx_t                        s1a_tag;
  logic                        s1a_nd;
  logic signed [DOUT_WIDTH-1:0] s1b_re;
  logic signed [DOUT_WIDTH-1:0] s1b_im;
  idx_t                        s1b_tag;
  logic                        s1b_nd;

  // slot index of each accepted input sample
  fft_sample_counter u_in_cnt (
    .clk   (clk),
    .rst_n (rst_n),
    .step  (din_nd),
    .count (in_tag),
    .wrap  ()
  );

  fft_bf2_section #(.X_WIDTH(DIN_WIDTH), .DELAY(8), .ROTATE(1'b0)) u_s0a (
    .clk (clk), .rst_n (rst_n),
    .x_re (din_re), .x_im (din_im), .x_tag (in_tag), .x_nd (din_nd),
    .z_re (s0a_re), .z_im (s0a_im), .z_tag (s0a_tag), .z_nd (s0a_nd)
  );

  fft_bf2_section #(.X_WIDTH(S0A_WIDTH), .DELAY(4), .ROTATE(1'b1)) u_s0b (
    .clk (clk), .rst_n (rst_n),
    .x_re (s0a_re), .x_im (s0a_im), .x_tag (s0a_tag), .x_nd (s0a_nd),
    .z_re (s0b_re), .z_im (s0b_im), .z_tag (s0b_tag), .z_nd (s0b_nd)
  );

  fft_twiddle_mult #(.X_WIDTH(S0_WIDTH)) u_tm (
    .clk (clk), .rst_n (rst_n),
    .x_re (s0b_re), .x_im (s0b_im), .x_tag (s0b_tag), .x_nd (s0b_nd),
    .z_re (tm_re), .z_im (tm_im), .z_tag (tm_tag), .z_nd (tm_nd)
  );

  fft_bf2_section #(.X_WIDTH(S0_WIDTH), .DELAY(2), .ROTATE(1'b0)) u_s1a (
    .clk (clk), .rst_n (rst_n),
    .x_re (tm_re), .x_im (tm_im), .x_tag (tm_tag), .x_nd (tm_nd),
    .z_re (s1a_re), .z_im (s1a_im), .z_tag (s1a_tag), .z_nd (s1a_nd)
  );

  fft_bf2_section #(.X_WIDTH(S1A_WIDTH), .DELAY(1), .ROTATE(1'b1)) u_s1b (
    .clk (clk), .rst_n (rst_n),
    .x_re (s1a_re), .x_im (s1a_im), .x_tag (s1a_tag), .x_nd (s1a_nd),
    .z_re (s1b_re), .z_im (s1b_im), .z_tag (s1b_tag), .z_nd (s1b_nd)
  );

  fft_output_ctrl #(.X_WIDTH(DOUT_WIDTH)) u_out (
    .clk (clk), .rst_n (rst_n),
    .x_re (s1b_re), .x_im (s1b_im), .x_tag (s1b_tag), .x_nd (s1b_nd),
    .dout_re (dout_re), .dout_im (dout_im), .dout_nd (dout_nd), .out_num (out_num)
  );

endmodule

`default_nettype wire

// File: bench/fft_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module fft_clock_gen #(
  parameter int PERIOD_NS = 100
) (
  output logic clk
);

  // starts low, first rising edge after half a period
  always
  begin
    clk = 1'b0;
    #(PERIOD_NS / 2);
    clk = 1'b1;
    #(PERIOD_NS / 2);
  end

endmodule

`default_nettype wire

// File: bench/fft_tb.sv
`timescale 1ns/1ns
`default_nettype none

module fft_tb;

  import fft_pkg::*;

  localparam int CLK_PERIOD_NS = 100;
  localparam int DIN_W = DIN_WIDTH_DEF;
  localparam int DOUT_W = DIN_W + 2 * STAGE_GROWTH;
  localparam int MAX_GAP = 3;
  localparam int PATTERN_LEN = 4;
  localparam int WAIT_LIMIT = 4 * FFT_LEN;
  // 12 data frames over all tests, plus one flush frame per test
  localparam int TOTAL_SAMPLES = (12 + 6) * FFT_LEN;
  localparam longint WATCHDOG_NS =
    longint'(TOTAL_SAMPLES) * (MAX_GAP + 1) * CLK_PERIOD_NS * 2;
  localparam real TWO_PI = 6.283185307179586;

  logic                     clk;
  logic                     rst_n;
  logic signed [DIN_W-1:0]  din_re;
  logic signed [DIN_W-1:0]  din_im;
  logic                     din_nd;
  logic signed [DOUT_W-1:0] dout_re;
  logic signed [DOUT_W-1:0] dout_im;
  logic                     dout_nd;
  idx_t                     out_num;

  int seed = 95789;
  int frame_re [FFT_LEN];
  int frame_im [FFT_LEN];
  int p4_re [PATTERN_LEN];
  int p4_im [PATTERN_LEN];
  int in_re_q [$];
  int in_im_q [$];
  int exp_re_q [$];
  int exp_im_q [$];
  int got_re_q [$];
  int got_im_q [$];
  int got_num_q [$];
  int accepted;
  int results;

  fft_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS)) u_clk (.clk(clk));

  fft_r22sdf_16 #(.DIN_WIDTH(DIN_W)) uut (
    .clk     (clk),
    .rst_n   (rst_n),
    .din_re  (din_re),
    .din_im  (din_im),
    .din_nd  (din_nd),
    .dout_re (dout_re),
    .dout_im (dout_im),
    .dout_nd (dout_nd),
    .out_num (out_num)
  );

  task automatic report_error(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      report_error($sformatf("[FAIL] %s: got %h, expected %h", name, got, exp));
  endtask

  function automatic int reverse_bits(input int v);
    int r;
    r = 0;
    for (int i = 0; i < FFT_LOG2; i++)
    begin
      if (v & (1 << i))
        r |= 1 << (FFT_LOG2 - 1 - i);
    end
    return r;
  endfunction

  function automatic int round_to_int(input real v);
    if (v >= 0.0)
      return $rtoi(v + 0.5);
    return -$rtoi(0.5 - v);
  endfunction

  // accepted inputs, counted where the DUT samples them
  always @(posedge clk)
  begin
    if (!rst_n)
      accepted = 0;
    else if (din_nd)
      accepted++;
  end

  // result r belongs to input 15 + r, so it needs 16 + r accepted inputs
  always @(negedge clk)
  begin
    if (!rst_n)
    begin
      results = 0;
      got_re_q.delete();
      got_im_q.delete();
      got_num_q.delete();
    end
    else if (dout_nd)
    begin
      if (accepted < results + FFT_LEN)
        report_error("dout_nd raised before its input sample was accepted");
      got_re_q.push_back(int'(dout_re));
      got_im_q.push_back(int'(dout_im));
      got_num_q.push_back(int'(out_num));
      results++;
    end
  end

  initial
  begin
    #(WATCHDOG_NS);
    report_error($sformatf("timeout: tests still running after %0d ns", WATCHDOG_NS));
  end

  task automatic apply_reset();
    @(negedge clk);
    rst_n = 1'b0;
    din_nd = 1'b0;
    din_re = '0;
    din_im = '0;
    repeat (3) @(negedge clk);
    check("dout_nd in reset", 32'(dout_nd), 32'd0);
    rst_n = 1'b1;
  endtask

  // one accepted sample, then idle cycles
  task automatic send_sample(input int re, input int im, input int gap);
    din_re = DIN_W'(re);
    din_im = DIN_W'(im);
    din_nd = 1'b1;
    @(negedge clk);
    din_nd = 1'b0;
    din_re = '0;
    din_im = '0;
    repeat (gap) @(negedge clk);
  endtask

  task automatic expect_quiet(input int cycles);
    repeat (cycles)
    begin
      check("dout_nd before first frame", 32'(dout_nd), 32'd0);
      check("out_num before first frame", 32'(out_num), 32'd0);
      @(negedge clk);
    end
  endtask

  // queue the scratch frame and its direct DFT
  task automatic push_frame();
    real acc_re;
    real acc_im;
    real theta;
    for (int k = 0; k < FFT_LEN; k++)
    begin
      acc_re = 0.0;
      acc_im = 0.0;
      for (int n = 0; n < FFT_LEN; n++)
      begin
        theta = TWO_PI * real'(n * k) / real'(FFT_LEN);
        acc_re = acc_re + real'(frame_re[n]) * $cos(theta) + real'(frame_im[n]) * $sin(theta);
        acc_im = acc_im + real'(frame_im[n]) * $cos(theta) - real'(frame_re[n]) * $sin(theta);
      end
      exp_re_q.push_back(round_to_int(acc_re));
      exp_im_q.push_back(round_to_int(acc_im));
    end
    for (int n = 0; n < FFT_LEN; n++)
    begin
      in_re_q.push_back(frame_re[n]);
      in_im_q.push_back(frame_im[n]);
    end
  endtask

  task automatic fill_constant(input int a, input int b);
    for (int n = 0; n < FFT_LEN; n++)
    begin
      frame_re[n] = a;
      frame_im[n] = b;
    end
  endtask

  task automatic fill_impulse(input int a);
    fill_constant(0, 0);
    frame_re[0] = a;
  endtask

  // four full-range random complex values
  task automatic draw_period4();
    int raw;
    for (int n = 0; n < PATTERN_LEN; n++)
    begin
      raw = $random(seed);
      p4_re[n] = raw >>> (32 - DIN_W);
      raw = $random(seed);
      p4_im[n] = raw >>> (32 - DIN_W);
    end
  endtask

  task automatic fill_period4();
    for (int n = 0; n < FFT_LEN; n++)
    begin
      frame_re[n] = p4_re[n % PATTERN_LEN];
      frame_im[n] = p4_im[n % PATTERN_LEN];
    end
  endtask

  task automatic compare_results();
    int frame;
    int bin;
    for (int r = 0; r < got_re_q.size(); r++)
    begin
      frame = r / FFT_LEN;
      bin = reverse_bits(r % FFT_LEN);
      check($sformatf("out_num result %0d", r), got_num_q[r], bin);
      check($sformatf("dout_re frame %0d bin %0d", frame, bin),
            got_re_q[r], exp_re_q[frame * FFT_LEN + bin]);
      check($sformatf("dout_im frame %0d bin %0d", frame, bin),
            got_im_q[r], exp_im_q[frame * FFT_LEN + bin]);
    end
  endtask

  // stream queued frames plus a zero flush frame, then collect and compare
  task automatic stream_frames(input int max_gap, input bit fill_check);
    int gap;
    int raw;
    int target;
    int waited;
    fill_constant(0, 0);
    push_frame();
    for (int i = 0; i < in_re_q.size(); i++)
    begin
      gap = 0;
      if (max_gap > 0)
      begin
        raw = $random(seed);
        gap = (raw & 32'h7fff_ffff) % (max_gap + 1);
      end
      send_sample(in_re_q[i], in_im_q[i], gap);
      // 15 samples in, nothing may be released yet
      if (fill_check && i == FFT_LEN - 2)
        expect_quiet(8);
    end
    target = in_re_q.size() - (FFT_LEN - 1);
    waited = 0;
    while (results < target && waited < WAIT_LIMIT)
    begin
      @(posedge clk);
      waited++;
    end
    if (results < target)
      report_error("timed out waiting for results after the flush frame");
    repeat (8) @(negedge clk);
    check("result count", results, target);
    compare_results();
    in_re_q.delete();
    in_im_q.delete();
    exp_re_q.delete();
    exp_im_q.delete();
  endtask

  task automatic test_reset();
    apply_reset();
    expect_quiet(10);
    fill_constant(300, -700);
    push_frame();
    stream_frames(0, 1'b1);
  endtask

  task automatic test_impulse();
    apply_reset();
    fill_impulse(1000);
    push_frame();
    fill_impulse(-2048);
    push_frame();
    stream_frames(0, 1'b0);
  endtask

  task automatic test_constant();
    apply_reset();
    // full growth into bin 0
    fill_constant(2047, -2048);
    push_frame();
    fill_constant(-1234, 567);
    push_frame();
    stream_frames(0, 1'b0);
  endtask

  task automatic test_period4();
    apply_reset();
    draw_period4();
    fill_period4();
    push_frame();
    draw_period4();
    fill_period4();
    push_frame();
    stream_frames(0, 1'b0);
  endtask

  // last pattern of the period-4 test, then a fresh one
  task automatic test_idle_gaps();
    apply_reset();
    fill_period4();
    push_frame();
    draw_period4();
    fill_period4();
    push_frame();
    stream_frames(MAX_GAP, 1'b0);
  endtask

  task automatic test_back_to_back();
    apply_reset();
    fill_impulse(777);
    push_frame();
    fill_constant(-500, 1500);
    push_frame();
    draw_period4();
    fill_period4();
    push_frame();
    stream_frames(0, 1'b0);
  endtask

  initial
  begin
    rst_n = 1'b0;
    din_re = '0;
    din_im = '0;
    din_nd = 1'b0;
    test_reset();
    test_impulse();
    test_constant();
    test_period4();
    test_idle_gaps();
    test_back_to_back();
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
+incdir+hdl
hdl/fft_pkg.sv
hdl/fft_delay_line.sv
hdl/fft_sample_counter.sv
hdl/fft_bf2_section.sv
hdl/fft_twiddle_mult.sv
hdl/fft_output_ctrl.sv
hdl/fft_r22sdf_16.sv
bench/fft_clock_gen.sv
bench/fft_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = fft_tb
FILELIST  = all.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
